// File: source/lsu_pkg.sv
// Load/store unit shared definitions
// Widths, data types and the opcode and function encodings

package lsu_pkg;

    parameter int DATA_WIDTH = 32;
    parameter int ADDR_WIDTH = 32;
    parameter int TAG_WIDTH  = 6;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [TAG_WIDTH-1:0]  tag_t;

    // Major opcode as delivered by the functional unit port
    typedef enum logic [6:0] {
        OPC_LOAD  = 7'b0000011,
        OPC_STORE = 7'b0100011,
        OPC_OTHER = 7'b0000000
    } lsu_opcode_e;

    // Internal function after opcode and funct3 decode
    typedef enum logic [1:0] {
        LSU_LW  = 2'b00,
        LSU_LB  = 2'b01,
        LSU_LBU = 2'b10,
        LSU_SW  = 2'b11
    } lsu_func_e;

    // funct3 encodings, insn[14:12]
    parameter logic [2:0] F3_B  = 3'b000;
    parameter logic [2:0] F3_W  = 3'b010;
    parameter logic [2:0] F3_BU = 3'b100;

endpackage

// File: source/lsu_if.sv
// LSU internal interfaces
// Address-stage request bus and the store queue forwarding lookup

`timescale 1ns/10ps

interface lsu_req_if;

    logic                valid;
    lsu_pkg::lsu_func_e  func;
    lsu_pkg::addr_t      addr;
    lsu_pkg::data_t      data;
    lsu_pkg::tag_t       tag;

    modport src  (output valid, func, addr, data, tag);
    modport sink (input  valid, func, addr, data, tag);

endinterface

interface lsu_sq_alloc_if;

    lsu_pkg::addr_t  lookup_addr;
    logic            fwd_hit;
    lsu_pkg::data_t  fwd_data;

    // Execute stage asks, store queue answers in the same cycle
    modport sq   (input  lookup_addr, output fwd_hit, fwd_data);
    modport exec (output lookup_addr, input  fwd_hit, fwd_data);

endinterface

// File: source/lsu_agen.sv
// LSU address generation
// Captures accepted instructions, decodes them and forms the effective address

`timescale 1ns/10ps

module lsu_agen (
    input  logic                 clk,
    input  logic                 n_rst,
    input  logic                 i_flush,
    input  logic                 i_fu_valid,
    input  lsu_pkg::lsu_opcode_e i_fu_opcode,
    input  lsu_pkg::data_t       i_fu_insn,
    input  lsu_pkg::data_t       i_fu_src_a,
    input  lsu_pkg::data_t       i_fu_src_b,
    input  lsu_pkg::tag_t        i_fu_tag,
    input  logic                 i_sq_full,
    output logic                 o_fu_stall,
    lsu_req_if.src               req
);

    logic                  s1_valid;
    lsu_pkg::lsu_opcode_e  s1_opcode;
    lsu_pkg::data_t        s1_insn;
    lsu_pkg::data_t        s1_src_a;
    lsu_pkg::data_t        s1_src_b;
    lsu_pkg::tag_t         s1_tag;
    logic                  accept;
    logic                  dec_ok;
    lsu_pkg::lsu_func_e    dec_func;
    logic [11:0]           imm12;
    lsu_pkg::addr_t        agen_addr;

    assign o_fu_stall = i_sq_full;
    assign accept     = i_fu_valid && !o_fu_stall;

    // Input capture
    always_ff @(posedge clk) begin
        if (accept) begin
            s1_opcode <= i_fu_opcode;
            s1_insn   <= i_fu_insn;
            s1_src_a  <= i_fu_src_a;
            s1_src_b  <= i_fu_src_b;
            s1_tag    <= i_fu_tag;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (~n_rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= accept && !i_flush;
        end
    end

    // Opcode and funct3 decode, unsupported combinations drop out here
    always_comb begin
        dec_ok   = 1'b0;
        dec_func = lsu_pkg::LSU_LW;
        imm12    = s1_insn[31:20];
        case (s1_opcode)
            lsu_pkg::OPC_LOAD: begin
                case (s1_insn[14:12])
                    lsu_pkg::F3_W: begin
                        dec_ok   = 1'b1;
                        dec_func = lsu_pkg::LSU_LW;
                    end
                    lsu_pkg::F3_B: begin
                        dec_ok   = 1'b1;
                        dec_func = lsu_pkg::LSU_LB;
                    end
                    lsu_pkg::F3_BU: begin
                        dec_ok   = 1'b1;
                        dec_func = lsu_pkg::LSU_LBU;
                    end
                    default: dec_ok = 1'b0;
                endcase
            end
            lsu_pkg::OPC_STORE: begin
                // S-format splits the immediate around rs2
                imm12    = {s1_insn[31:25], s1_insn[11:7]};
                dec_ok   = (s1_insn[14:12] == lsu_pkg::F3_W);
                dec_func = lsu_pkg::LSU_SW;
            end
            default: dec_ok = 1'b0;
        endcase
    end

    assign agen_addr = s1_src_a + {{(lsu_pkg::ADDR_WIDTH-12){imm12[11]}}, imm12};

    // Address stage register
    always_ff @(posedge clk) begin
        req.func <= dec_func;
        req.addr <= agen_addr;
        req.data <= s1_src_b;
        req.tag  <= s1_tag;
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (~n_rst) begin
            req.valid <= 1'b0;
        end else if (i_flush) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= s1_valid && dec_ok;
        end
    end

endmodule

// File: source/lsu_sq.sv
// LSU store queue
// Holds completed stores until the ROB retires them, forwards data to loads

`timescale 1ns/10ps

module lsu_sq #(
    parameter int SQ_DEPTH = 8
) (
    input  logic            clk,
    input  logic            n_rst,
    input  logic            i_flush,
    lsu_req_if.sink         req,
    lsu_sq_alloc_if.sq      fwd,
    input  logic            i_rob_retire_en,
    input  lsu_pkg::tag_t   i_rob_retire_tag,
    output logic            o_full,
    output logic            o_wr_en,
    output lsu_pkg::addr_t  o_wr_addr,
    output lsu_pkg::data_t  o_wr_data
);

    localparam int PTR_W = (SQ_DEPTH > 1) ? $clog2(SQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(SQ_DEPTH + 1);

    lsu_pkg::addr_t     sq_addr [SQ_DEPTH];
    lsu_pkg::data_t     sq_data [SQ_DEPTH];
    lsu_pkg::tag_t      sq_tag  [SQ_DEPTH];
    logic [PTR_W-1:0]   head;
    logic [PTR_W-1:0]   tail;
    logic [CNT_W-1:0]   count;
    logic               alloc;
    logic               retire;
    logic               store_pending;

    function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] ptr, input int off);
        int sum;
        sum = int'(ptr) + off;
        if (sum >= SQ_DEPTH) begin
            sum = sum - SQ_DEPTH;
        end
        return sum[PTR_W-1:0];
    endfunction

    assign alloc  = req.valid && (req.func == lsu_pkg::LSU_SW) && !i_flush;
    assign retire = i_rob_retire_en && (count != '0) && (sq_tag[head] == i_rob_retire_tag)
                    && !i_flush;

    // The store sitting in the address stage is counted as already allocated
    assign store_pending = req.valid && (req.func == lsu_pkg::LSU_SW);
    assign o_full        = (int'(count) + int'(store_pending)) >= (SQ_DEPTH - 1);

    // Head store goes to memory on retire
    assign o_wr_en   = retire;
    assign o_wr_addr = sq_addr[head];
    assign o_wr_data = sq_data[head];

    always_ff @(posedge clk) begin
        if (alloc) begin
            sq_addr[tail] <= req.addr;
            sq_data[tail] <= req.data;
            sq_tag[tail]  <= req.tag;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (~n_rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (i_flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc) begin
                tail <= ptr_add(tail, 1);
            end
            if (retire) begin
                head <= ptr_add(head, 1);
            end
            count <= count + CNT_W'(alloc) - CNT_W'(retire);
        end
    end

    // Forwarding lookup, walking oldest to youngest so the youngest match wins
    always_comb begin
        logic [PTR_W-1:0] idx;
        fwd.fwd_hit  = 1'b0;
        fwd.fwd_data = '0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            idx = ptr_add(head, i);
            if ((i < int'(count)) &&
                (sq_addr[idx][lsu_pkg::ADDR_WIDTH-1:2] == fwd.lookup_addr[lsu_pkg::ADDR_WIDTH-1:2]))
            begin
                fwd.fwd_hit  = 1'b1;
                fwd.fwd_data = sq_data[idx];
            end
        end
    end

endmodule

// File: source/lsu_dmem.sv
// LSU data memory
// Word-addressed array, combinational read and clocked write

`timescale 1ns/10ps

module lsu_dmem #(
    parameter int DMEM_DEPTH = 256
) (
    input  logic            clk,
    input  logic            i_wr_en,
    input  lsu_pkg::addr_t  i_wr_addr,
    input  lsu_pkg::data_t  i_wr_data,
    input  lsu_pkg::addr_t  i_rd_addr,
    output lsu_pkg::data_t  o_rd_data
);

    // Depth is a power of two, so the low word-address bits give the modulo
    localparam int IDX_W = (DMEM_DEPTH > 1) ? $clog2(DMEM_DEPTH) : 1;

    lsu_pkg::data_t    mem [DMEM_DEPTH];
    logic [IDX_W-1:0]  wr_idx;
    logic [IDX_W-1:0]  rd_idx;

    assign wr_idx = i_wr_addr[IDX_W+1:2];
    assign rd_idx = i_rd_addr[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[wr_idx] <= i_wr_data;
        end
    end

    assign o_rd_data = mem[rd_idx];

endmodule

// File: source/lsu_exec.sv
// LSU execute stage
// Merges forwarded and memory data, aligns bytes and drives the CDB register

`timescale 1ns/10ps

module lsu_exec (
    input  logic            clk,
    input  logic            n_rst,
    input  logic            i_flush,
    lsu_req_if.sink         req,
    lsu_sq_alloc_if.exec    fwd,
    output lsu_pkg::addr_t  o_rd_addr,
    input  lsu_pkg::data_t  i_rd_data,
    output logic            o_cdb_en,
    output lsu_pkg::data_t  o_cdb_data,
    output lsu_pkg::tag_t   o_cdb_tag
);

    lsu_pkg::data_t  load_word;
    logic [7:0]      load_byte;
    lsu_pkg::data_t  result;

    assign o_rd_addr       = req.addr;
    assign fwd.lookup_addr = req.addr;

    // Queued store data takes precedence over memory
    assign load_word = fwd.fwd_hit ? fwd.fwd_data : i_rd_data;

    // Little-endian byte lane
    always_comb begin
        case (req.addr[1:0])
            2'd0:    load_byte = load_word[7:0];
            2'd1:    load_byte = load_word[15:8];
            2'd2:    load_byte = load_word[23:16];
            default: load_byte = load_word[31:24];
        endcase
    end

    always_comb begin
        case (req.func)
            lsu_pkg::LSU_LW:  result = load_word;
            lsu_pkg::LSU_LB:  result = {{(lsu_pkg::DATA_WIDTH-8){load_byte[7]}}, load_byte};
            lsu_pkg::LSU_LBU: result = {{(lsu_pkg::DATA_WIDTH-8){1'b0}}, load_byte};
            default:          result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        o_cdb_data <= result;
        o_cdb_tag  <= req.tag;
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (~n_rst) begin
            o_cdb_en <= 1'b0;
        end else if (i_flush) begin
            o_cdb_en <= 1'b0;
        end else begin
            o_cdb_en <= req.valid;
        end
    end

endmodule

// File: source/lsu_top.sv
// Load/store unit top level
// Address generation, store queue, data memory and execute stage

`timescale 1ns/10ps

module lsu_top #(
    parameter int SQ_DEPTH   = 8,
    parameter int DMEM_DEPTH = 256
) (
    input  logic                 clk,
    input  logic                 n_rst,
    input  logic                 i_flush,

    // Functional unit port
    input  logic                 i_fu_valid,
    input  lsu_pkg::lsu_opcode_e i_fu_opcode,
    input  lsu_pkg::data_t       i_fu_insn,
    input  lsu_pkg::data_t       i_fu_src_a,
    input  lsu_pkg::data_t       i_fu_src_b,
    input  lsu_pkg::tag_t        i_fu_tag,
    output logic                 o_fu_stall,

    // ROB retire
    input  logic                 i_rob_retire_en,
    input  lsu_pkg::tag_t        i_rob_retire_tag,

    // Common data bus
    output logic                 o_cdb_en,
    output lsu_pkg::data_t       o_cdb_data,
    output lsu_pkg::tag_t        o_cdb_tag
);

    logic            sq_full;
    logic            wr_en;
    lsu_pkg::addr_t  wr_addr;
    lsu_pkg::data_t  wr_data;
    lsu_pkg::addr_t  rd_addr;
    lsu_pkg::data_t  rd_data;

    lsu_req_if       req_if ();
    lsu_sq_alloc_if  fwd_if ();

    lsu_agen lsu_agen_inst (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_flush     (i_flush),
        .i_fu_valid  (i_fu_valid),
        .i_fu_opcode (i_fu_opcode),
        .i_fu_insn   (i_fu_insn),
        .i_fu_src_a  (i_fu_src_a),
        .i_fu_src_b  (i_fu_src_b),
        .i_fu_tag    (i_fu_tag),
        .i_sq_full   (sq_full),
        .o_fu_stall  (o_fu_stall),
        .req         (req_if.src)
    );

    lsu_sq #(
        .SQ_DEPTH (SQ_DEPTH)
    ) lsu_sq_inst (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_flush          (i_flush),
        .req              (req_if.sink),
        .fwd              (fwd_if.sq),
        .i_rob_retire_en  (i_rob_retire_en),
        .i_rob_retire_tag (i_rob_retire_tag),
        .o_full           (sq_full),
        .o_wr_en          (wr_en),
        .o_wr_addr        (wr_addr),
        .o_wr_data        (wr_data)
    );

    lsu_dmem #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) lsu_dmem_inst (
        .clk       (clk),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_data (wr_data),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data)
    );

    lsu_exec lsu_exec_inst (
        .clk        (clk),
        .n_rst      (n_rst),
        .i_flush    (i_flush),
        .req        (req_if.sink),
        .fwd        (fwd_if.exec),
        .o_rd_addr  (rd_addr),
        .i_rd_data  (rd_data),
        .o_cdb_en   (o_cdb_en),
        .o_cdb_data (o_cdb_data),
        .o_cdb_tag  (o_cdb_tag)
    );

endmodule

// File: sim/lsu_tb.sv
// LSU testbench
// Random loads, stores, retires and flushes checked against a reference model

`timescale 1ns/10ps

module lsu_tb;

    localparam int SQ_DEPTH       = 8;
    localparam int NWORDS         = 16;
    localparam int N_BYTE         = 32;
    localparam int N_FWD          = 8;
    localparam int N_MIX          = 200;
    localparam int N_FLUSH        = 8;
    localparam int N_OPS          = 2 * NWORDS + N_BYTE + 4 * N_FWD + N_MIX + 3 * N_FLUSH;
    localparam int TIMEOUT_CYCLES = N_OPS * 10 + 200;
    localparam logic [31:0]    SEED      = 32'h1d50_a47f;
    localparam lsu_pkg::addr_t BASE_ADDR = 32'h0000_0400;

    logic                 clk;
    logic                 n_rst;
    logic                 i_flush;
    logic                 i_fu_valid;
    lsu_pkg::lsu_opcode_e i_fu_opcode;
    lsu_pkg::data_t       i_fu_insn;
    lsu_pkg::data_t       i_fu_src_a;
    lsu_pkg::data_t       i_fu_src_b;
    lsu_pkg::tag_t        i_fu_tag;
    logic                 o_fu_stall;
    logic                 i_rob_retire_en;
    lsu_pkg::tag_t        i_rob_retire_tag;
    logic                 o_cdb_en;
    lsu_pkg::data_t       o_cdb_data;
    lsu_pkg::tag_t        o_cdb_tag;

    // Reference model: retired memory, pending stores, expected CDB results
    lsu_pkg::data_t mem_model [NWORDS];
    int             ps_word  [$];
    lsu_pkg::data_t ps_data  [$];
    lsu_pkg::tag_t  ps_tag   [$];
    int             ps_due   [$];
    lsu_pkg::data_t exp_data [$];
    lsu_pkg::tag_t  exp_tag  [$];
    int             exp_due  [$];

    int             cycle;
    int             errors;
    lsu_pkg::tag_t  next_tag;

    lsu_top #(
        .SQ_DEPTH (SQ_DEPTH)
    ) dut (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_flush          (i_flush),
        .i_fu_valid       (i_fu_valid),
        .i_fu_opcode      (i_fu_opcode),
        .i_fu_insn        (i_fu_insn),
        .i_fu_src_a       (i_fu_src_a),
        .i_fu_src_b       (i_fu_src_b),
        .i_fu_tag         (i_fu_tag),
        .o_fu_stall       (o_fu_stall),
        .i_rob_retire_en  (i_rob_retire_en),
        .i_rob_retire_tag (i_rob_retire_tag),
        .o_cdb_en         (o_cdb_en),
        .o_cdb_data       (o_cdb_data),
        .o_cdb_tag        (o_cdb_tag)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string why);
        errors++;
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_data(input string name, input lsu_pkg::data_t got,
                              input lsu_pkg::data_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_tag(input string name, input lsu_pkg::tag_t got,
                             input lsu_pkg::tag_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                               $time, name, got, exp));
        end
    endtask

    // Stores in the queue or in the address stage, against the stall margin
    function automatic logic model_stall();
        int n;
        n = 0;
        foreach (ps_due[i]) begin
            if (ps_due[i] <= cycle + 1) begin
                n++;
            end
        end
        return n >= SQ_DEPTH - 1;
    endfunction

    // Each result must show up exactly in its due cycle, in issue order
    task automatic check_cdb();
        if (o_cdb_en !== 1'b0) begin
            if (exp_due.size() == 0) begin
                fail_run($sformatf("A CDB result with tag %h came at %0t but none was expected",
                                   o_cdb_tag, $time));
            end else if (exp_due[0] != cycle) begin
                fail_run($sformatf("The CDB result for tag %h came at %0t, in the wrong cycle",
                                   exp_tag[0], $time));
            end else begin
                check_tag("o_cdb_tag", o_cdb_tag, exp_tag[0]);
                check_data("o_cdb_data", o_cdb_data, exp_data[0]);
                void'(exp_due.pop_front());
                void'(exp_tag.pop_front());
                void'(exp_data.pop_front());
            end
        end else if (exp_due.size() > 0 && exp_due[0] <= cycle) begin
            fail_run($sformatf("The CDB result for tag %h never arrived, seen at %0t",
                               exp_tag[0], $time));
        end
    endtask

    // Falling edge: count, check outputs, return inputs to idle
    task automatic tick();
        @(negedge clk);
        cycle++;
        if (cycle > TIMEOUT_CYCLES) begin
            fail_run($sformatf("The run timed out after %0d cycles", cycle));
        end else begin
            check_cdb();
            check_bit("o_fu_stall", o_fu_stall, model_stall());
            i_fu_valid      = 1'b0;
            i_rob_retire_en = 1'b0;
            i_flush         = 1'b0;
        end
    endtask

    // Retire the oldest store once it sits in the queue
    task automatic try_retire();
        if (!i_rob_retire_en && ps_due.size() > 0 && ps_due[0] <= cycle) begin
            i_rob_retire_en       = 1'b1;
            i_rob_retire_tag      = ps_tag[0];
            mem_model[ps_word[0]] = ps_data[0];
            void'(ps_word.pop_front());
            void'(ps_data.pop_front());
            void'(ps_tag.pop_front());
            void'(ps_due.pop_front());
        end
    endtask

    function automatic lsu_pkg::data_t model_load(input lsu_pkg::lsu_func_e func,
                                                  input int word, input int offset);
        lsu_pkg::data_t w;
        logic [7:0]     b;
        w = mem_model[word];
        // Later entries are younger, so the last match wins
        foreach (ps_word[i]) begin
            if (ps_word[i] == word) begin
                w = ps_data[i];
            end
        end
        b = w[8*offset +: 8];
        case (func)
            lsu_pkg::LSU_LB:  return {{24{b[7]}}, b};
            lsu_pkg::LSU_LBU: return {24'h0, b};
            default:          return w;
        endcase
    endfunction

    // Offer one instruction until accepted and record what the model expects
    task automatic issue_op(input lsu_pkg::lsu_func_e func, input int word, input int offset,
                            input lsu_pkg::data_t data);
        lsu_pkg::addr_t addr;
        logic [11:0]    imm;
        logic [2:0]     f3;
        addr       = BASE_ADDR + lsu_pkg::addr_t'(word * 4 + offset);
        imm        = 12'($urandom_range(0, 4095));
        i_fu_src_a = addr - {{20{imm[11]}}, imm};
        i_fu_src_b = data;
        i_fu_tag   = next_tag;
        if (func == lsu_pkg::LSU_SW) begin
            i_fu_opcode = lsu_pkg::OPC_STORE;
            i_fu_insn   = {imm[11:5], 5'd7, 5'd5, 3'b010, imm[4:0], 7'b0100011};
        end else begin
            // RISC-V funct3: LW 010, LB 000, LBU 100
            f3 = (func == lsu_pkg::LSU_LW) ? 3'b010 : (func == lsu_pkg::LSU_LB) ? 3'b000 : 3'b100;
            i_fu_opcode = lsu_pkg::OPC_LOAD;
            i_fu_insn   = {imm, 5'd5, f3, 5'd6, 7'b0000011};
        end
        i_fu_valid = 1'b1;
        // Stalled offers must be ignored by the DUT
        while (o_fu_stall) begin
            try_retire();
            tick();
            i_fu_valid = 1'b1;
        end
        exp_tag.push_back(next_tag);
        exp_due.push_back(cycle + 3);
        if (func == lsu_pkg::LSU_SW) begin
            exp_data.push_back('0);
            ps_word.push_back(word);
            ps_data.push_back(data);
            ps_tag.push_back(next_tag);
            ps_due.push_back(cycle + 3);
        end else begin
            exp_data.push_back(model_load(func, word, offset));
        end
        next_tag++;
    endtask

    task automatic issue_rand_load(input int word);
        lsu_pkg::lsu_func_e func;
        int                 sel;
        sel  = $urandom_range(0, 2);
        func = (sel == 0) ? lsu_pkg::LSU_LW : (sel == 1) ? lsu_pkg::LSU_LB : lsu_pkg::LSU_LBU;
        issue_op(func, word, (func == lsu_pkg::LSU_LW) ? 0 : $urandom_range(0, 3), '0);
    endtask

    task automatic drain();
        while (exp_due.size() > 0 || ps_due.size() > 0) begin
            tick();
            try_retire();
        end
    endtask

    task automatic flush_all();
        i_flush = 1'b1;
        exp_data.delete();
        exp_tag.delete();
        exp_due.delete();
        ps_word.delete();
        ps_data.delete();
        ps_tag.delete();
        ps_due.delete();
    endtask

    initial begin
        int w;
        void'($urandom(SEED));
        n_rst            = 1'b0;
        i_flush          = 1'b0;
        i_fu_valid       = 1'b0;
        i_fu_opcode      = lsu_pkg::OPC_OTHER;
        i_fu_insn        = '0;
        i_fu_src_a       = '0;
        i_fu_src_b       = '0;
        i_fu_tag         = '0;
        i_rob_retire_en  = 1'b0;
        i_rob_retire_tag = '0;
        cycle            = 0;
        errors           = 0;
        next_tag         = '0;
        repeat (8) @(negedge clk);
        n_rst = 1'b1;
        tick();
        check_bit("o_cdb_en", o_cdb_en, 1'b0);
        check_bit("o_fu_stall", o_fu_stall, 1'b0);

        // Fill the words under test, then read them back
        for (int i = 0; i < NWORDS; i++) begin
            tick();
            issue_op(lsu_pkg::LSU_SW, i, 0, $urandom);
        end
        drain();
        for (int i = 0; i < NWORDS; i++) begin
            tick();
            issue_op(lsu_pkg::LSU_LW, i, 0, '0);
        end
        drain();

        // Byte loads at random offsets
        repeat (N_BYTE) begin
            tick();
            issue_op(($urandom_range(0, 1) == 0) ? lsu_pkg::LSU_LB : lsu_pkg::LSU_LBU,
                     $urandom_range(0, NWORDS - 1), $urandom_range(0, 3), '0);
        end
        drain();

        // Forwarding, back to back and with a gap
        repeat (N_FWD) begin
            w = $urandom_range(0, NWORDS - 1);
            tick();
            issue_op(lsu_pkg::LSU_SW, w, 0, $urandom);
            tick();
            issue_rand_load(w);
            tick();
            issue_op(lsu_pkg::LSU_SW, w, 0, $urandom);
            tick();
            tick();
            issue_rand_load(w);
        end
        drain();

        // Random mix, stores outpace retires so the queue fills up
        repeat (N_MIX) begin
            tick();
            if ($urandom_range(0, 2) == 0) begin
                try_retire();
            end
            w = $urandom_range(0, 9);
            if (w < 4) begin
                issue_rand_load($urandom_range(0, NWORDS - 1));
            end else if (w < 8) begin
                issue_op(lsu_pkg::LSU_SW, $urandom_range(0, NWORDS - 1), 0, $urandom);
            end
        end
        drain();

        // Flush with work in flight, later loads see retired memory only
        repeat (N_FLUSH) begin
            w = $urandom_range(0, NWORDS - 1);
            tick();
            issue_op(lsu_pkg::LSU_SW, w, 0, $urandom);
            tick();
            issue_rand_load($urandom_range(0, NWORDS - 1));
            repeat ($urandom_range(0, 2)) tick();
            tick();
            flush_all();
            tick();
            issue_op(lsu_pkg::LSU_LW, w, 0, '0);
            drain();
        end

        repeat (5) tick();
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: lsu_top.f
source/lsu_pkg.sv
source/lsu_if.sv
source/lsu_agen.sv
source/lsu_sq.sv
source/lsu_dmem.sv
source/lsu_exec.sv
source/lsu_top.sv
sim/lsu_tb.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - source/lsu_pkg.sv
  - source/lsu_if.sv
  - source/lsu_agen.sv
  - source/lsu_sq.sv
  - source/lsu_dmem.sv
  - source/lsu_exec.sv
  - source/lsu_top.sv
  - target: test
    files:
      - sim/lsu_tb.sv
